// ==== include/dcache_params.svh ====
// sizes are fixed for 32-bit byte addresses, two-word blocks and two ways; other values are untested
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// data word and byte address width
`define DCACHE_WORD_W 32

// set index bits, address bits [5:3]
`define DCACHE_INDEX_W 3

// number of sets, must equal 2**DCACHE_INDEX_W
`define DCACHE_SETS 8

// tag bits, address bits [31:6]
`define DCACHE_TAG_W 26

// byte offset bits, address bits [1:0], ignored by the cache
`define DCACHE_BYTE_OFF_W 2

// block word select sits just above the byte offset, one bit wide
// tag + index + word select + byte offset must add up to DCACHE_WORD_W

`endif

// ==== design/dcache_pkg.sv ====
// shared cache types; widths come from dcache_params.svh, word-aligned accesses only
`include "dcache_params.svh"

package dcache_pkg;

  // meaningful widths
  typedef logic [`DCACHE_WORD_W-1:0]  word_t;
  typedef logic [`DCACHE_TAG_W-1:0]   tag_t;
  typedef logic [`DCACHE_INDEX_W-1:0] index_t;
  typedef logic                       way_t;
  typedef logic                       blk_t;

  // one cache frame, data[1] is the upper word of the block
  typedef struct packed {
    logic           valid;
    logic           dirty;
    tag_t           tag;
    word_t [1:0]    data;
  } dcache_frame_t;

  // cpu side request, held until dhit
  typedef struct packed {
    logic  ren;
    logic  wen;
    word_t addr;
    word_t store;
  } cpu_req_t;

  // memory side request, one word per transfer
  typedef struct packed {
    logic  ren;
    logic  wen;
    word_t addr;
    word_t store;
  } mem_req_t;

  // one frame update per cycle
  // en writes wdata into the word picked by wsel
  // set_valid also loads tag
  typedef struct packed {
    logic   en;
    way_t   way;
    index_t index;
    blk_t   wsel;
    word_t  wdata;
    logic   set_valid;
    logic   set_dirty;
    logic   clr_dirty;
    tag_t   tag;
    logic   lru_we;
    way_t   lru;
  } frame_upd_t;

  typedef enum logic [3:0] {
    idle,
    wb0,
    wb1,
    fetch0,
    fetch1,
    flush_scan,
    flush0,
    flush1,
    halted
  } cache_state_t;

endpackage

// ==== design/dcache_frames.sv ====
// two ways of DCACHE_SETS frames plus one LRU bit per set; one update per cycle, all state reset
`timescale 1ns/1ns
`include "dcache_params.svh"

module dcache_frames (
  input  logic                      CLK,
  input  logic                      nRST,
  input  dcache_pkg::index_t        cpu_index,
  input  dcache_pkg::index_t        flush_index,
  input  dcache_pkg::frame_upd_t    upd,
  output dcache_pkg::dcache_frame_t cpu_frame0,
  output dcache_pkg::dcache_frame_t cpu_frame1,
  output dcache_pkg::way_t          cpu_lru,
  output dcache_pkg::dcache_frame_t flush_frame0,
  output dcache_pkg::dcache_frame_t flush_frame1
);

  // frame store, first index is the way
  dcache_pkg::dcache_frame_t frames [0:1][0:`DCACHE_SETS-1];

  // lru bit names the way to evict next
  dcache_pkg::way_t lru_bits [0:`DCACHE_SETS-1];

  always_ff @(posedge CLK or negedge nRST)
  begin
    if (!nRST)
    begin
      for (int w = 0; w < 2; w++)
      begin
        for (int s = 0; s < `DCACHE_SETS; s++)
        begin
          frames[w][s] <= '0;
        end
      end
      for (int s = 0; s < `DCACHE_SETS; s++)
      begin
        lru_bits[s] <= '0;
      end
    end
    else
    begin
      // word write, hit store or fill
      if (upd.en)
      begin
        frames[upd.way][upd.index].data[upd.wsel] <= upd.wdata;
      end
      // tag goes in with valid
      if (upd.set_valid)
      begin
        frames[upd.way][upd.index].valid <= 1'b1;
        frames[upd.way][upd.index].tag   <= upd.tag;
      end
      // set wins over clear
      if (upd.set_dirty)
      begin
        frames[upd.way][upd.index].dirty <= 1'b1;
      end
      else if (upd.clr_dirty)
      begin
        frames[upd.way][upd.index].dirty <= 1'b0;
      end
      if (upd.lru_we)
      begin
        lru_bits[upd.index] <= upd.lru;
      end
    end
  end

  // cpu set read port
  assign cpu_frame0 = frames[0][cpu_index];
  assign cpu_frame1 = frames[1][cpu_index];
  assign cpu_lru    = lru_bits[cpu_index];

  // flush row read port, walked by the controller
  assign flush_frame0 = frames[0][flush_index];
  assign flush_frame1 = frames[1][flush_index];

  // a block only turns dirty through a store that also keeps it valid
  property p_dirty_needs_valid;
    @(posedge CLK) disable iff (!nRST)
      upd.set_dirty |-> (upd.set_valid && upd.en);
  endproperty
  a_dirty_needs_valid: assert property (p_dirty_needs_valid)
    else $error("dcache_frames: dirty set without valid and word write");

endmodule

// ==== design/dcache_lookup.sv ====
// combinational tag compare for the cpu set; load word is only meaningful while hit is high
`timescale 1ns/1ns
`include "dcache_params.svh"

module dcache_lookup (
  input  dcache_pkg::cpu_req_t      req,
  input  dcache_pkg::dcache_frame_t frame0,
  input  dcache_pkg::dcache_frame_t frame1,
  input  dcache_pkg::way_t          lru,
  output logic                      hit,
  output dcache_pkg::way_t          hit_way,
  output dcache_pkg::way_t          victim_way,
  output logic                      victim_dirty,
  output dcache_pkg::word_t         load
);

  dcache_pkg::tag_t req_tag;
  dcache_pkg::blk_t req_blk;
  logic             hit0;
  logic             hit1;

  // address split, byte offset dropped
  assign req_tag = req.addr[`DCACHE_WORD_W-1 -: `DCACHE_TAG_W];
  assign req_blk = req.addr[`DCACHE_BYTE_OFF_W];

  // a hit needs valid and a matching tag
  assign hit0 = frame0.valid && (frame0.tag == req_tag);
  assign hit1 = frame1.valid && (frame1.tag == req_tag);

  assign hit     = hit0 | hit1;
  assign hit_way = hit1;

  // word within the hit block
  always_comb
  begin
    if (hit1)
    begin
      load = frame1.data[req_blk];
    end
    else
    begin
      load = frame0.data[req_blk];
    end
  end

  // lru names the victim
  assign victim_way   = lru;
  assign victim_dirty = lru ? frame1.dirty : frame0.dirty;

  // fills always go to the lru way after a miss, so one block never lives in both ways
  always_comb
  begin
    a_one_way_hit: assert final ($isunknown({hit0, hit1}) || !(hit0 && hit1))
      else $error("dcache_lookup: both ways hit");
  end

endmodule

// ==== design/dcache_ctrl.sv ====
// one request at a time; cpu must hold its request until dhit, halt is taken only from idle
`timescale 1ns/1ns
`include "dcache_params.svh"

module dcache_ctrl (
  input  logic                      CLK,
  input  logic                      nRST,
  input  dcache_pkg::cpu_req_t      req,
  input  logic                      halt,
  input  logic                      hit,
  input  dcache_pkg::way_t          hit_way,
  input  dcache_pkg::way_t          victim_way,
  input  logic                      victim_dirty,
  input  dcache_pkg::dcache_frame_t cpu_frame0,
  input  dcache_pkg::dcache_frame_t cpu_frame1,
  input  dcache_pkg::dcache_frame_t flush_frame0,
  input  dcache_pkg::dcache_frame_t flush_frame1,
  input  dcache_pkg::word_t         mem_load,
  input  logic                      dwait,
  output dcache_pkg::frame_upd_t    upd,
  output dcache_pkg::index_t        flush_index,
  output dcache_pkg::mem_req_t      mem,
  output logic                      dhit,
  output logic                      flushed
);

  dcache_pkg::cache_state_t  state;
  dcache_pkg::cache_state_t  next_state;
  dcache_pkg::way_t          fill_way;
  dcache_pkg::way_t          next_fill_way;
  dcache_pkg::way_t          flush_way;
  dcache_pkg::way_t          next_flush_way;
  dcache_pkg::index_t        next_flush_index;
  dcache_pkg::tag_t          req_tag;
  dcache_pkg::index_t        req_index;
  dcache_pkg::blk_t          req_blk;
  dcache_pkg::dcache_frame_t victim_frame;
  dcache_pkg::dcache_frame_t flush_frame;
  logic                      access;

  assign req_tag   = req.addr[`DCACHE_WORD_W-1 -: `DCACHE_TAG_W];
  assign req_index = req.addr[`DCACHE_BYTE_OFF_W+1 +: `DCACHE_INDEX_W];
  assign req_blk   = req.addr[`DCACHE_BYTE_OFF_W];
  assign access    = req.ren | req.wen;

  // way latched at the miss, lru does not move until the next hit
  assign victim_frame = fill_way ? cpu_frame1 : cpu_frame0;
  assign flush_frame  = flush_way ? flush_frame1 : flush_frame0;

  always_ff @(posedge CLK or negedge nRST)
  begin
    if (!nRST)
    begin
      state       <= dcache_pkg::idle;
      fill_way    <= '0;
      flush_way   <= '0;
      flush_index <= '0;
    end
    else
    begin
      state       <= next_state;
      fill_way    <= next_fill_way;
      flush_way   <= next_flush_way;
      flush_index <= next_flush_index;
    end
  end

  always_comb
  begin
    next_state       = state;
    next_fill_way    = fill_way;
    next_flush_way   = flush_way;
    next_flush_index = flush_index;
    upd              = '0;
    mem              = '0;
    dhit             = 1'b0;

    case (state)
      dcache_pkg::idle:
      begin
        // halt beats any request
        if (halt)
        begin
          next_state       = dcache_pkg::flush_scan;
          next_flush_index = '0;
        end
        else if (access && hit)
        begin
          dhit       = 1'b1;
          upd.way    = hit_way;
          upd.index  = req_index;
          // other way becomes the victim
          upd.lru_we = 1'b1;
          upd.lru    = ~hit_way;
          if (req.wen)
          begin
            upd.en        = 1'b1;
            upd.wsel      = req_blk;
            upd.wdata     = req.store;
            upd.set_valid = 1'b1;
            upd.set_dirty = 1'b1;
            upd.tag       = req_tag;
          end
        end
        else if (access)
        begin
          // miss, dirty victim goes out first
          next_fill_way = victim_way;
          next_state    = victim_dirty ? dcache_pkg::wb0 : dcache_pkg::fetch0;
        end
      end

      dcache_pkg::wb0,
      dcache_pkg::wb1:
      begin
        mem.wen   = 1'b1;
        mem.addr  = {victim_frame.tag, req_index, state == dcache_pkg::wb1,
                     {`DCACHE_BYTE_OFF_W{1'b0}}};
        mem.store = victim_frame.data[state == dcache_pkg::wb1];
        if (!dwait)
        begin
          next_state = (state == dcache_pkg::wb0) ? dcache_pkg::wb1 : dcache_pkg::fetch0;
        end
      end

      dcache_pkg::fetch0,
      dcache_pkg::fetch1:
      begin
        mem.ren   = 1'b1;
        mem.addr  = {req_tag, req_index, state == dcache_pkg::fetch1,
                     {`DCACHE_BYTE_OFF_W{1'b0}}};
        upd.way   = fill_way;
        upd.index = req_index;
        upd.wsel  = (state == dcache_pkg::fetch1);
        upd.wdata = mem_load;
        upd.tag   = req_tag;
        if (!dwait)
        begin
          upd.en = 1'b1;
          if (state == dcache_pkg::fetch1)
          begin
            // block complete, fresh tag and clean
            upd.set_valid = 1'b1;
            upd.clr_dirty = 1'b1;
            next_state    = dcache_pkg::idle;
          end
          else
          begin
            next_state = dcache_pkg::fetch1;
          end
        end
      end

      dcache_pkg::flush_scan:
      begin
        // way 0 first, a set is revisited until both ways are clean
        if (flush_frame0.dirty)
        begin
          next_flush_way = 1'b0;
          next_state     = dcache_pkg::flush0;
        end
        else if (flush_frame1.dirty)
        begin
          next_flush_way = 1'b1;
          next_state     = dcache_pkg::flush0;
        end
        else if (flush_index == dcache_pkg::index_t'(`DCACHE_SETS - 1))
        begin
          next_state = dcache_pkg::halted;
        end
        else
        begin
          next_flush_index = flush_index + 1'b1;
        end
      end

      dcache_pkg::flush0,
      dcache_pkg::flush1:
      begin
        mem.wen   = 1'b1;
        mem.addr  = {flush_frame.tag, flush_index, state == dcache_pkg::flush1,
                     {`DCACHE_BYTE_OFF_W{1'b0}}};
        mem.store = flush_frame.data[state == dcache_pkg::flush1];
        upd.way   = flush_way;
        upd.index = flush_index;
        if (!dwait)
        begin
          if (state == dcache_pkg::flush1)
          begin
            upd.clr_dirty = 1'b1;
            next_state    = dcache_pkg::flush_scan;
          end
          else
          begin
            next_state = dcache_pkg::flush1;
          end
        end
      end

      // terminal until reset
      dcache_pkg::halted:
      begin
        next_state = dcache_pkg::halted;
      end

      default:
      begin
        next_state = dcache_pkg::idle;
      end
    endcase
  end

  assign flushed = (state == dcache_pkg::halted);

  // memory port carries one direction per transfer
  a_mem_one_dir: assert property (@(posedge CLK) disable iff (!nRST) !(mem.ren && mem.wen))
    else $error("dcache_ctrl: mem ren and wen both high");

  // flushed holds until reset
  a_flushed_holds: assert property (@(posedge CLK) disable iff (!nRST) flushed |=> flushed)
    else $error("dcache_ctrl: flushed fell before reset");

endmodule

// ==== design/dcache_top.sv ====
// data cache top; memory port waits on dwait, cpu request must stay stable until dhit
`timescale 1ns/1ns
`include "dcache_params.svh"

module dcache_top (
  input  logic                 CLK,
  input  logic                 nRST,
  input  dcache_pkg::cpu_req_t cpu_req,
  input  logic                 halt,
  output logic                 dhit,
  output dcache_pkg::word_t    dload,
  output logic                 flushed,
  output dcache_pkg::mem_req_t mem,
  input  dcache_pkg::word_t    mem_load,
  input  logic                 dwait
);

  dcache_pkg::frame_upd_t    upd;
  dcache_pkg::index_t        flush_index;
  dcache_pkg::dcache_frame_t cpu_frame0;
  dcache_pkg::dcache_frame_t cpu_frame1;
  dcache_pkg::dcache_frame_t flush_frame0;
  dcache_pkg::dcache_frame_t flush_frame1;
  dcache_pkg::way_t          cpu_lru;
  logic                      hit;
  dcache_pkg::way_t          hit_way;
  dcache_pkg::way_t          victim_way;
  logic                      victim_dirty;

  // storage, set picked straight from the request address
  dcache_frames u_frames (
    .CLK          (CLK),
    .nRST         (nRST),
    .cpu_index    (cpu_req.addr[`DCACHE_BYTE_OFF_W+1 +: `DCACHE_INDEX_W]),
    .flush_index  (flush_index),
    .upd          (upd),
    .cpu_frame0   (cpu_frame0),
    .cpu_frame1   (cpu_frame1),
    .cpu_lru      (cpu_lru),
    .flush_frame0 (flush_frame0),
    .flush_frame1 (flush_frame1)
  );

  // hit and load word go straight to the cpu
  dcache_lookup u_lookup (
    .req          (cpu_req),
    .frame0       (cpu_frame0),
    .frame1       (cpu_frame1),
    .lru          (cpu_lru),
    .hit          (hit),
    .hit_way      (hit_way),
    .victim_way   (victim_way),
    .victim_dirty (victim_dirty),
    .load         (dload)
  );

  dcache_ctrl u_ctrl (
    .CLK          (CLK),
    .nRST         (nRST),
    .req          (cpu_req),
    .halt         (halt),
    .hit          (hit),
    .hit_way      (hit_way),
    .victim_way   (victim_way),
    .victim_dirty (victim_dirty),
    .cpu_frame0   (cpu_frame0),
    .cpu_frame1   (cpu_frame1),
    .flush_frame0 (flush_frame0),
    .flush_frame1 (flush_frame1),
    .mem_load     (mem_load),
    .dwait        (dwait),
    .upd          (upd),
    .flush_index  (flush_index),
    .mem          (mem),
    .dhit         (dhit),
    .flushed      (flushed)
  );

endmodule

// ==== testbench/dcache_tb.sv ====
// memory model covers the lowest 1 KiB only, so test tags stay below 16; word-aligned accesses
`timescale 1ns/1ns
`include "dcache_params.svh"

module dcache_tb;

  localparam int          MEM_IDX_W      = 8;
  localparam int          MEM_WORDS      = 1 << MEM_IDX_W;
  localparam int          ACCESS_TIMEOUT = 500;
  localparam int          FLUSH_TIMEOUT  = 4000;
  localparam int          RANDOM_OPS     = 300;
  localparam logic [31:0] FILL_KEY       = 32'h6b2e_91d4;

  logic                 CLK;
  logic                 nRST;
  dcache_pkg::cpu_req_t cpu_req;
  logic                 halt;
  logic                 dhit;
  dcache_pkg::word_t    dload;
  logic                 flushed;
  dcache_pkg::mem_req_t mem;
  dcache_pkg::word_t    mem_load;
  logic                 dwait;

  // memory model, shadow copy and store marks, all word indexed
  dcache_pkg::word_t mem_words [0:MEM_WORDS-1];
  dcache_pkg::word_t shadow    [0:MEM_WORDS-1];
  logic              written   [0:MEM_WORDS-1];

  integer seed;
  logic   next_wait;
  int     checks;
  int     mismatches;
  int     timeouts;
  int     reads_done;
  int     writes_done;
  int     post_flush_writes;
  int     watch_hits;
  logic   abort;
  logic   watch_en;
  logic [`DCACHE_WORD_W-1:`DCACHE_BYTE_OFF_W+1] watch_block;

  dcache_top uut (
    .CLK      (CLK),
    .nRST     (nRST),
    .cpu_req  (cpu_req),
    .halt     (halt),
    .dhit     (dhit),
    .dload    (dload),
    .flushed  (flushed),
    .mem      (mem),
    .mem_load (mem_load),
    .dwait    (dwait)
  );

  always #50 CLK = ~CLK;

  function automatic int word_index(input dcache_pkg::word_t addr);
    word_index = int'(addr[`DCACHE_BYTE_OFF_W +: MEM_IDX_W]);
  endfunction

  // initial memory pattern, every address bit matters
  function automatic dcache_pkg::word_t fill_value(input dcache_pkg::word_t addr);
    fill_value = addr ^ FILL_KEY;
  endfunction

  function automatic dcache_pkg::word_t make_addr(input int tag, input int index, input int blk);
    dcache_pkg::word_t a;
    a = '0;
    a[`DCACHE_WORD_W-1 -: `DCACHE_TAG_W]              = dcache_pkg::tag_t'(tag);
    a[`DCACHE_BYTE_OFF_W+1 +: `DCACHE_INDEX_W]        = dcache_pkg::index_t'(index);
    a[`DCACHE_BYTE_OFF_W]                             = blk[0];
    make_addr = a;
  endfunction

  // reference result, the last value stored or the initial pattern
  function automatic dcache_pkg::word_t expected_load(input dcache_pkg::word_t addr);
    expected_load = shadow[word_index(addr)];
  endfunction

  task automatic check_value(input string name, input dcache_pkg::word_t got,
                             input dcache_pkg::word_t exp);
    checks++;
    if (got !== exp)
    begin
      mismatches++;
      $display("FAILED %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  // one cpu access, called on a falling edge, returns on a falling edge
  task automatic access(input logic is_store, input dcache_pkg::word_t addr,
                        input dcache_pkg::word_t data);
    int   cycles;
    logic done;
    if (!abort)
    begin
      cycles        = 0;
      done          = 1'b0;
      cpu_req.ren   = !is_store;
      cpu_req.wen   = is_store;
      cpu_req.addr  = addr;
      cpu_req.store = is_store ? data : '0;
      while (!done && cycles < ACCESS_TIMEOUT)
      begin
        @(posedge CLK);
        done = dhit;
        cycles++;
      end
      @(negedge CLK);
      cpu_req = '0;
      if (!done)
      begin
        $display("timeout: no dhit for address %h within %0d cycles", addr, ACCESS_TIMEOUT);
        timeouts++;
        abort = 1'b1;
      end
    end
  endtask

  // compare every acknowledged load, track every acknowledged store
  always @(posedge CLK)
  begin
    if (nRST && dhit)
    begin
      if (cpu_req.ren)
      begin
        check_value("dload", dload, expected_load(cpu_req.addr));
      end
      if (cpu_req.wen)
      begin
        shadow[word_index(cpu_req.addr)]  = cpu_req.store;
        written[word_index(cpu_req.addr)] = 1'b1;
      end
    end
  end

  // memory model, a word moves on an edge with dwait low
  assign mem_load = mem_words[word_index(mem.addr)];

  always @(posedge CLK)
  begin
    if (nRST && !dwait && (mem.ren || mem.wen))
    begin
      if (mem.wen)
      begin
        mem_words[word_index(mem.addr)] <= mem.store;
        writes_done++;
      end
      if (mem.ren)
      begin
        reads_done++;
      end
      if (watch_en && mem.addr[`DCACHE_WORD_W-1:`DCACHE_BYTE_OFF_W+1] == watch_block)
      begin
        watch_hits++;
      end
    end
    // any write request once flushed is an error, waited or not
    if (nRST && flushed && mem.wen)
    begin
      post_flush_writes++;
    end
  end

  // wait level drawn on the rising edge, driven on the falling one
  always @(posedge CLK)
  begin
    next_wait = (($random(seed) & 3) == 0);
  end

  always @(negedge CLK)
  begin
    dwait = next_wait;
  end

  initial
  begin
    dcache_pkg::word_t addr_a;
    dcache_pkg::word_t addr_b;
    dcache_pkg::word_t addr_c;
    dcache_pkg::word_t data;
    int                tag;
    int                index;
    int                blk;
    int                cycles;
    int                reads_before;
    int                writes_before;
    logic              is_store;

    CLK               = 1'b0;
    nRST              = 1'b0;
    cpu_req           = '0;
    halt              = 1'b0;
    dwait             = 1'b0;
    next_wait         = 1'b0;
    seed              = 32'hdd039ee6;
    checks            = 0;
    mismatches        = 0;
    timeouts          = 0;
    reads_done        = 0;
    writes_done       = 0;
    post_flush_writes = 0;
    watch_hits        = 0;
    abort             = 1'b0;
    watch_en          = 1'b0;
    watch_block       = '0;
    for (int i = 0; i < MEM_WORDS; i++)
    begin
      mem_words[i] = fill_value(dcache_pkg::word_t'(i << 2));
      shadow[i]    = fill_value(dcache_pkg::word_t'(i << 2));
      written[i]   = 1'b0;
    end

    repeat (10) @(negedge CLK);
    nRST = 1'b1;
    @(negedge CLK);

    // outputs quiet after reset
    check_value("dhit", dhit, '0);
    check_value("flushed", flushed, '0);
    check_value("mem.ren", mem.ren, '0);
    check_value("mem.wen", mem.wen, '0);

    // cold miss fetches both words
    reads_before = reads_done;
    access(1'b0, make_addr(1, 0, 1), '0);
    check_value("reads_done delta", reads_done - reads_before, 2);

    // store then both words of the block
    access(1'b1, make_addr(2, 1, 0), 32'hcafe_0123);
    access(1'b0, make_addr(2, 1, 0), '0);
    access(1'b0, make_addr(2, 1, 1), '0);

    // lru, A and B share set 2, A touched last
    addr_a = make_addr(8, 2, 0);
    addr_b = make_addr(9, 2, 1);
    addr_c = make_addr(10, 2, 0);
    access(1'b0, addr_a, '0);
    access(1'b1, addr_b, 32'h1357_9bdf);
    reads_before = reads_done;
    access(1'b0, addr_a, '0);
    check_value("reads_done delta", reads_done - reads_before, 0);
    watch_block   = addr_a[`DCACHE_WORD_W-1:`DCACHE_BYTE_OFF_W+1];
    watch_hits    = 0;
    watch_en      = 1'b1;
    writes_before = writes_done;
    access(1'b0, addr_c, '0);
    // dirty B goes out, two words
    check_value("writes_done delta", writes_done - writes_before, 2);
    reads_before = reads_done;
    access(1'b0, addr_a, '0);
    check_value("reads_done delta", reads_done - reads_before, 0);
    watch_en = 1'b0;
    check_value("watch_hits", watch_hits, 0);

    // three tags per set force dirty evictions
    for (int n = 0; n < RANDOM_OPS; n++)
    begin
      tag      = 4 + (($random(seed) & 32'h7fff_ffff) % 3);
      index    = $random(seed) & 7;
      blk      = $random(seed) & 1;
      is_store = $random(seed) & 1;
      data     = $random(seed);
      access(is_store, make_addr(tag, index, blk), data);
    end

    // halt flush
    if (!abort)
    begin
      halt   = 1'b1;
      cycles = 0;
      while (!flushed && cycles < FLUSH_TIMEOUT)
      begin
        @(posedge CLK);
        cycles++;
      end
      if (!flushed)
      begin
        $display("timeout: flushed did not rise within %0d cycles", FLUSH_TIMEOUT);
        timeouts++;
      end
      else
      begin
        repeat (20) @(negedge CLK);
        check_value("flushed", flushed, 1'b1);
        check_value("post_flush_writes", post_flush_writes, 0);
        for (int i = 0; i < MEM_WORDS; i++)
        begin
          if (written[i])
          begin
            check_value("mem_words", mem_words[i], shadow[i]);
          end
        end
      end
    end

    $display("checks %0d, mismatches %0d, timeouts %0d", checks, mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0)
    begin
      $display("TESTBENCH PASSED");
    end
    else
    begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+include
design/dcache_pkg.sv
design/dcache_frames.sv
design/dcache_lookup.sv
design/dcache_ctrl.sv
design/dcache_top.sv
testbench/dcache_tb.sv

// ==== Bender.yml ====
package:
  name: dcache

export_include_dirs:
  - include

sources:
  - design/dcache_pkg.sv
  - design/dcache_frames.sv
  - design/dcache_lookup.sv
  - design/dcache_ctrl.sv
  - design/dcache_top.sv
  - target: simulation
    files:
      - testbench/dcache_tb.sv
